//--- logic/cacc_csb_pkg.sv
`default_nettype none

package cacc_csb_pkg;

  ////////////////////
  // packet types
  ////////////////////
  typedef logic [62:0] csb_req_pd_t;   // addr, wdat, write, nposted, priv, be, level
  typedef logic [33:0] csb_resp_pd_t;  // kind, error, data
  typedef logic [21:0] csb_addr_t;     // word address
  typedef logic [31:0] csb_data_t;

  // request field positions
  localparam int REQ_ADDR_LSB    = 0;   // 21:0
  localparam int REQ_WDAT_LSB    = 22;  // 53:22
  localparam int REQ_WRITE_BIT   = 54;
  localparam int REQ_NPOSTED_BIT = 55;
  // priv, byte enables and level above bit 55 go unused

  // response field positions
  localparam int RESP_ERROR_BIT = 32;
  localparam int RESP_KIND_BIT  = 33;

  // response kinds
  localparam logic RESP_KIND_RD = 1'b0;  // read data report
  localparam logic RESP_KIND_WR = 1'b1;  // non-posted write ack

endpackage

`default_nettype wire

//--- logic/cacc_reg_pkg.sv
`default_nettype none

package cacc_reg_pkg;

  typedef logic [11:0] reg_offset_t;  // byte offset in the 4 KB window

  ////////////////////
  // register map
  ////////////////////
  localparam reg_offset_t POINTER_OFS        = 12'h000;
  localparam reg_offset_t STATUS_OFS         = 12'h004;
  localparam reg_offset_t OP_ENABLE_OFS      = 12'h008;
  localparam reg_offset_t MISC_CFG_OFS       = 12'h00c;
  localparam reg_offset_t DATAOUT_SIZE_0_OFS = 12'h010;
  localparam reg_offset_t DATAOUT_SIZE_1_OFS = 12'h014;
  localparam reg_offset_t DATAOUT_ADDR_OFS   = 12'h018;
  localparam reg_offset_t BATCHES_OFS        = 12'h01c;
  localparam reg_offset_t DUAL_BASE_OFS      = 12'h008;  // single below, ping-pong above

  // field positions inside the 32-bit words
  localparam int PTR_PRODUCER_BIT = 0;
  localparam int PTR_CONSUMER_BIT = 16;
  localparam int STATUS_0_LSB     = 0;
  localparam int STATUS_1_LSB     = 16;
  localparam int WIDTH_LSB        = 0;   // dataout_size_0
  localparam int HEIGHT_LSB       = 16;  // dataout_size_0
  localparam int CHANNEL_LSB      = 0;   // dataout_size_1

  typedef logic [12:0] dim_t;    // width, height, channel
  typedef logic [4:0]  batch_t;

  typedef enum logic [1:0] {
    GROUP_IDLE    = 2'd0,
    GROUP_PENDING = 2'd1,
    GROUP_RUNNING = 2'd2
  } group_status_e;

  localparam int OP_EN_DELAY = 3;  // reg2dp_op_en pipe depth

endpackage

`default_nettype wire

//--- logic/cacc_reg_access_if.sv
`timescale 1ns/100ps
`default_nettype none

// decoded register access, one beat per accepted request
interface cacc_reg_access_if;

  cacc_reg_pkg::reg_offset_t offset;   // byte offset
  cacc_csb_pkg::csb_data_t   wr_data;
  logic                      wr_en;    // strobe
  logic                      rd_en;    // strobe
  logic                      nposted;  // write wants an ack

  modport req (output offset, wr_data, wr_en, rd_en, nposted);

  // register groups only see the write side
  modport group (input offset, wr_data, wr_en);

  modport resp (input wr_en, rd_en, nposted);

endinterface

`default_nettype wire

//--- logic/cacc_cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

// live config of one ping-pong group
interface cacc_cfg_if;

  logic                    op_en;
  logic                    conv_mode;
  cacc_reg_pkg::dim_t      width;
  cacc_reg_pkg::dim_t      height;
  cacc_reg_pkg::dim_t      channel;
  cacc_csb_pkg::csb_data_t addr;
  cacc_reg_pkg::batch_t    batches;

  modport group (output op_en, conv_mode, width, height, channel, addr, batches);
  modport sel (input op_en, conv_mode, width, height, channel, addr, batches);

endinterface

`default_nettype wire

//--- logic/cacc_csb_req_stage.sv
`timescale 1ns/100ps
`default_nettype none

module cacc_csb_req_stage (
  input  wire logic                      nvdla_core_clk,
  input  wire logic                      nvdla_core_rstn,
  input  wire logic                      req_pvld,
  input  wire cacc_csb_pkg::csb_req_pd_t req_pd,
  cacc_reg_access_if.req                 acc
);

  logic                      req_vld_q;
  cacc_csb_pkg::csb_req_pd_t req_pd_q;   // held packet
  cacc_csb_pkg::csb_addr_t   req_addr;
  cacc_csb_pkg::csb_data_t   req_wdat;
  logic                      req_write;
  logic                      req_nposted;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld_q <= 1'b0;
    end else begin
      req_vld_q <= req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (req_pvld) req_pd_q <= req_pd;  // capture only on a beat
  end

  ////////////////////
  // unpack
  ////////////////////
  assign req_addr    = req_pd_q[cacc_csb_pkg::REQ_ADDR_LSB +: $bits(cacc_csb_pkg::csb_addr_t)];
  assign req_wdat    = req_pd_q[cacc_csb_pkg::REQ_WDAT_LSB +: $bits(cacc_csb_pkg::csb_data_t)];
  assign req_write   = req_pd_q[cacc_csb_pkg::REQ_WRITE_BIT];
  assign req_nposted = req_pd_q[cacc_csb_pkg::REQ_NPOSTED_BIT];

  // word addr -> byte offset, only the 4 KB window decodes
  assign acc.offset  = {req_addr[9:0], 2'b00};
  assign acc.wr_data = req_wdat;
  assign acc.wr_en   = req_vld_q & req_write;
  assign acc.rd_en   = req_vld_q & ~req_write;
  assign acc.nposted = req_nposted;

  // valid feeds the response path two stages down, so it must be clean
  a_req_pvld_known: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !$isunknown(req_pvld));

endmodule

`default_nettype wire

//--- logic/cacc_single_group.sv
`timescale 1ns/100ps
`default_nettype none

module cacc_single_group (
  input  wire logic                        nvdla_core_clk,
  input  wire logic                        nvdla_core_rstn,
  cacc_reg_access_if.group                 acc,
  input  wire logic                        consumer,
  input  wire cacc_reg_pkg::group_status_e status_0,
  input  wire cacc_reg_pkg::group_status_e status_1,
  output logic                             producer,
  output cacc_csb_pkg::csb_data_t          rd_data
);

  logic sel_s;  // offset in the single group

  assign sel_s = (acc.offset < cacc_reg_pkg::DUAL_BASE_OFS);

  // producer pointer, sw owned
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (acc.wr_en && sel_s && acc.offset == cacc_reg_pkg::POINTER_OFS) begin
      producer <= acc.wr_data[cacc_reg_pkg::PTR_PRODUCER_BIT];
    end
  end

  // read mux, consumer and status are read only
  always_comb begin
    rd_data = '0;
    if (sel_s) begin
      case (acc.offset)
        cacc_reg_pkg::POINTER_OFS: begin
          rd_data[cacc_reg_pkg::PTR_PRODUCER_BIT] = producer;
          rd_data[cacc_reg_pkg::PTR_CONSUMER_BIT] = consumer;
        end
        cacc_reg_pkg::STATUS_OFS: begin
          rd_data[cacc_reg_pkg::STATUS_0_LSB +: 2] = status_0;
          rd_data[cacc_reg_pkg::STATUS_1_LSB +: 2] = status_1;
        end
        default: rd_data = '0;  // hole in the map
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/cacc_dual_group.sv
`timescale 1ns/100ps
`default_nettype none

module cacc_dual_group #(
  parameter bit GROUP_ID = 1'b0  // which ping-pong half
) (
  input  wire logic               nvdla_core_clk,
  input  wire logic               nvdla_core_rstn,
  cacc_reg_access_if.group        acc,
  input  wire logic               producer,
  input  wire logic               consumer,
  input  wire logic               done,
  cacc_cfg_if.group               cfg,
  output cacc_csb_pkg::csb_data_t rd_data
);

  logic                    sel_d;     // addressed through the producer pointer
  logic                    wr_field;  // write lands, group idle
  logic                    op_en;
  logic                    conv_mode;
  cacc_reg_pkg::dim_t      width;
  cacc_reg_pkg::dim_t      height;
  cacc_reg_pkg::dim_t      channel;
  cacc_csb_pkg::csb_data_t addr;
  cacc_reg_pkg::batch_t    batches;

  assign sel_d    = (acc.offset >= cacc_reg_pkg::DUAL_BASE_OFS) && (producer == GROUP_ID);
  assign wr_field = acc.wr_en & sel_d & ~op_en;  // running group is locked

  ////////////////////
  // config fields
  ////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en     <= 1'b0;
      conv_mode <= 1'b0;
      width     <= '0;
      height    <= '0;
      channel   <= '0;
      addr      <= '0;
      batches   <= '0;
    end else begin
      if (wr_field && acc.offset == cacc_reg_pkg::OP_ENABLE_OFS) begin
        op_en <= acc.wr_data[0];  // kick
      end else if (done && consumer == GROUP_ID) begin
        op_en <= 1'b0;            // datapath finished this group
      end
      if (wr_field) begin
        case (acc.offset)
          cacc_reg_pkg::MISC_CFG_OFS: conv_mode <= acc.wr_data[0];
          cacc_reg_pkg::DATAOUT_SIZE_0_OFS: begin
            width  <= acc.wr_data[cacc_reg_pkg::WIDTH_LSB +: $bits(cacc_reg_pkg::dim_t)];
            height <= acc.wr_data[cacc_reg_pkg::HEIGHT_LSB +: $bits(cacc_reg_pkg::dim_t)];
          end
          cacc_reg_pkg::DATAOUT_SIZE_1_OFS:
            channel <= acc.wr_data[cacc_reg_pkg::CHANNEL_LSB +: $bits(cacc_reg_pkg::dim_t)];
          cacc_reg_pkg::DATAOUT_ADDR_OFS: addr <= acc.wr_data;
          cacc_reg_pkg::BATCHES_OFS: batches <= acc.wr_data[$bits(cacc_reg_pkg::batch_t)-1:0];
          default: ;  // op_enable handled above
        endcase
      end
    end
  end

  // readback, zero when not selected so the top can OR
  always_comb begin
    rd_data = '0;
    if (sel_d) begin
      case (acc.offset)
        cacc_reg_pkg::OP_ENABLE_OFS: rd_data[0] = op_en;
        cacc_reg_pkg::MISC_CFG_OFS:  rd_data[0] = conv_mode;
        cacc_reg_pkg::DATAOUT_SIZE_0_OFS: begin
          rd_data[cacc_reg_pkg::WIDTH_LSB +: $bits(cacc_reg_pkg::dim_t)]  = width;
          rd_data[cacc_reg_pkg::HEIGHT_LSB +: $bits(cacc_reg_pkg::dim_t)] = height;
        end
        cacc_reg_pkg::DATAOUT_SIZE_1_OFS:
          rd_data[cacc_reg_pkg::CHANNEL_LSB +: $bits(cacc_reg_pkg::dim_t)] = channel;
        cacc_reg_pkg::DATAOUT_ADDR_OFS: rd_data = addr;
        cacc_reg_pkg::BATCHES_OFS: rd_data[$bits(cacc_reg_pkg::batch_t)-1:0] = batches;
        default: rd_data = '0;
      endcase
    end
  end

  assign cfg.op_en     = op_en;
  assign cfg.conv_mode = conv_mode;
  assign cfg.width     = width;
  assign cfg.height    = height;
  assign cfg.channel   = channel;
  assign cfg.addr      = addr;
  assign cfg.batches   = batches;

  // only a sw kick through the producer pointer starts a group
  a_op_en_rise: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $rose(op_en) |-> $past(acc.wr_en && sel_d && acc.offset == cacc_reg_pkg::OP_ENABLE_OFS));

endmodule

`default_nettype wire

//--- logic/cacc_consumer_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cacc_consumer_ctrl (
  input  wire logic                   nvdla_core_clk,
  input  wire logic                   nvdla_core_rstn,
  input  wire logic                   done,
  cacc_cfg_if.sel                     cfg0,
  cacc_cfg_if.sel                     cfg1,
  output logic                        consumer,
  output cacc_reg_pkg::group_status_e status_0,
  output cacc_reg_pkg::group_status_e status_1,
  output logic                        op_en,
  output logic                        conv_mode,
  output cacc_reg_pkg::dim_t          dataout_width,
  output cacc_reg_pkg::dim_t          dataout_height,
  output cacc_reg_pkg::dim_t          dataout_channel,
  output cacc_csb_pkg::csb_data_t     dataout_addr,
  output cacc_reg_pkg::batch_t        batches
);

  logic                                 op_en_sel;   // consumer group's op_en
  logic [cacc_reg_pkg::OP_EN_DELAY-1:0] op_en_pipe;

  // consumer flips each time the datapath finishes
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= 1'b0;
    end else if (done) begin
      consumer <= ~consumer;
    end
  end

  ////////////////////
  // group status
  ////////////////////
  always_comb begin
    if (!cfg0.op_en) status_0 = cacc_reg_pkg::GROUP_IDLE;
    else if (!consumer) status_0 = cacc_reg_pkg::GROUP_RUNNING;
    else status_0 = cacc_reg_pkg::GROUP_PENDING;  // queued behind group 1
  end

  always_comb begin
    if (!cfg1.op_en) status_1 = cacc_reg_pkg::GROUP_IDLE;
    else if (consumer) status_1 = cacc_reg_pkg::GROUP_RUNNING;
    else status_1 = cacc_reg_pkg::GROUP_PENDING;
  end

  // datapath sees the consumer half
  assign op_en_sel       = consumer ? cfg1.op_en     : cfg0.op_en;
  assign conv_mode       = consumer ? cfg1.conv_mode : cfg0.conv_mode;
  assign dataout_width   = consumer ? cfg1.width     : cfg0.width;
  assign dataout_height  = consumer ? cfg1.height    : cfg0.height;
  assign dataout_channel = consumer ? cfg1.channel   : cfg0.channel;
  assign dataout_addr    = consumer ? cfg1.addr      : cfg0.addr;
  assign batches         = consumer ? cfg1.batches   : cfg0.batches;

  // op_en lags the fields so they settle first, done flushes
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_pipe <= '0;
    end else if (done) begin
      op_en_pipe <= '0;
    end else begin
      op_en_pipe <= {op_en_pipe[cacc_reg_pkg::OP_EN_DELAY-2:0], op_en_sel};
    end
  end

  assign op_en = op_en_pipe[cacc_reg_pkg::OP_EN_DELAY-1];

  a_consumer_on_done: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $changed(consumer) |-> $past(done));

endmodule

`default_nettype wire

//--- logic/cacc_csb_resp_stage.sv
`timescale 1ns/100ps
`default_nettype none

module cacc_csb_resp_stage (
  input  wire logic                    nvdla_core_clk,
  input  wire logic                    nvdla_core_rstn,
  cacc_reg_access_if.resp              acc,
  input  wire cacc_csb_pkg::csb_data_t s_rd_data,
  input  wire cacc_csb_pkg::csb_data_t d0_rd_data,
  input  wire cacc_csb_pkg::csb_data_t d1_rd_data,
  output logic                         resp_valid,
  output cacc_csb_pkg::csb_resp_pd_t   resp_pd
);

  cacc_csb_pkg::csb_data_t    rd_data;  // unselected groups give 0
  cacc_csb_pkg::csb_resp_pd_t resp_w;

  assign rd_data = s_rd_data | d0_rd_data | d1_rd_data;

  // pack, error never set
  always_comb begin
    resp_w = '0;
    resp_w[cacc_csb_pkg::RESP_ERROR_BIT] = 1'b0;
    if (acc.rd_en) begin
      resp_w[cacc_csb_pkg::RESP_KIND_BIT] = cacc_csb_pkg::RESP_KIND_RD;
      resp_w[$bits(cacc_csb_pkg::csb_data_t)-1:0] = rd_data;
    end else begin
      resp_w[cacc_csb_pkg::RESP_KIND_BIT] = cacc_csb_pkg::RESP_KIND_WR;  // data stays 0
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= acc.rd_en | (acc.wr_en & acc.nposted);  // posted writes are silent
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (acc.rd_en || (acc.wr_en && acc.nposted)) resp_pd <= resp_w;
  end

endmodule

`default_nettype wire

//--- logic/cacc_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module cacc_regfile (
  input  wire logic                      nvdla_core_clk,
  input  wire logic                      nvdla_core_rstn,
  input  wire logic                      csb2cacc_req_pvld,
  input  wire cacc_csb_pkg::csb_req_pd_t csb2cacc_req_pd,
  input  wire logic                      dp2reg_done,
  output logic                           csb2cacc_req_prdy,
  output logic                           cacc2csb_resp_valid,
  output cacc_csb_pkg::csb_resp_pd_t     cacc2csb_resp_pd,
  output logic                           reg2dp_op_en,
  output logic                           reg2dp_conv_mode,
  output cacc_reg_pkg::dim_t             reg2dp_dataout_width,
  output cacc_reg_pkg::dim_t             reg2dp_dataout_height,
  output cacc_reg_pkg::dim_t             reg2dp_dataout_channel,
  output cacc_csb_pkg::csb_data_t        reg2dp_dataout_addr,
  output cacc_reg_pkg::batch_t           reg2dp_batches
);

  logic                        producer;
  logic                        consumer;
  cacc_reg_pkg::group_status_e status_0;
  cacc_reg_pkg::group_status_e status_1;
  cacc_csb_pkg::csb_data_t     s_rd_data;
  cacc_csb_pkg::csb_data_t     d0_rd_data;
  cacc_csb_pkg::csb_data_t     d1_rd_data;

  cacc_reg_access_if acc_if ();
  cacc_cfg_if        cfg0_if ();
  cacc_cfg_if        cfg1_if ();

  assign csb2cacc_req_prdy = 1'b1;  // no back-pressure, one request per cycle

  ////////////////////
  // csb side
  ////////////////////
  cacc_csb_req_stage u_req (
    .nvdla_core_clk, .nvdla_core_rstn,
    .req_pvld (csb2cacc_req_pvld),
    .req_pd   (csb2cacc_req_pd),
    .acc      (acc_if.req)
  );

  cacc_csb_resp_stage u_resp (
    .nvdla_core_clk, .nvdla_core_rstn,
    .acc        (acc_if.resp),
    .s_rd_data, .d0_rd_data, .d1_rd_data,
    .resp_valid (cacc2csb_resp_valid),
    .resp_pd    (cacc2csb_resp_pd)
  );

  ////////////////////
  // register groups
  ////////////////////
  cacc_single_group u_single (
    .nvdla_core_clk, .nvdla_core_rstn,
    .acc (acc_if.group), .consumer, .status_0, .status_1, .producer, .rd_data (s_rd_data)
  );

  cacc_dual_group #(.GROUP_ID(1'b0)) u_dual_0 (
    .nvdla_core_clk, .nvdla_core_rstn, .acc (acc_if.group), .producer, .consumer,
    .done (dp2reg_done), .cfg (cfg0_if.group), .rd_data (d0_rd_data)
  );

  cacc_dual_group #(.GROUP_ID(1'b1)) u_dual_1 (
    .nvdla_core_clk, .nvdla_core_rstn, .acc (acc_if.group), .producer, .consumer,
    .done (dp2reg_done), .cfg (cfg1_if.group), .rd_data (d1_rd_data)
  );

  cacc_consumer_ctrl u_consumer (
    .nvdla_core_clk, .nvdla_core_rstn,
    .done (dp2reg_done), .cfg0 (cfg0_if.sel), .cfg1 (cfg1_if.sel),
    .consumer, .status_0, .status_1,
    .op_en           (reg2dp_op_en),
    .conv_mode       (reg2dp_conv_mode),
    .dataout_width   (reg2dp_dataout_width),
    .dataout_height  (reg2dp_dataout_height),
    .dataout_channel (reg2dp_dataout_channel),
    .dataout_addr    (reg2dp_dataout_addr),
    .batches         (reg2dp_batches)
  );

endmodule

`default_nettype wire

//--- verification/cacc_tb_tasks.svh
  ////////////////////
  // reference model
  ////////////////////
  logic                    m_producer;
  logic                    m_consumer;
  logic [1:0]              m_op_en;        // one bit per group
  logic [1:0]              m_conv_mode;
  cacc_reg_pkg::dim_t      m_width [2];
  cacc_reg_pkg::dim_t      m_height [2];
  cacc_reg_pkg::dim_t      m_channel [2];
  cacc_csb_pkg::csb_data_t m_addr [2];
  cacc_reg_pkg::batch_t    m_batches [2];

  // idle unless enabled, running only while it is the consumer
  function automatic cacc_reg_pkg::group_status_e status_of(input logic g);
    if (m_op_en[g] == 1'b0) return cacc_reg_pkg::GROUP_IDLE;
    if (m_consumer == g) return cacc_reg_pkg::GROUP_RUNNING;
    return cacc_reg_pkg::GROUP_PENDING;
  endfunction

  function automatic cacc_csb_pkg::csb_data_t model_read(input cacc_reg_pkg::reg_offset_t ofs);
    cacc_csb_pkg::csb_data_t d;
    d = '0;
    case (ofs)
      cacc_reg_pkg::POINTER_OFS:        d = {15'd0, m_consumer, 15'd0, m_producer};
      cacc_reg_pkg::STATUS_OFS:         d = {14'd0, status_of(1'b1), 14'd0, status_of(1'b0)};
      cacc_reg_pkg::OP_ENABLE_OFS:      d = {31'd0, m_op_en[m_producer]};
      cacc_reg_pkg::MISC_CFG_OFS:       d = {31'd0, m_conv_mode[m_producer]};
      cacc_reg_pkg::DATAOUT_SIZE_0_OFS: d = {3'd0, m_height[m_producer], 3'd0, m_width[m_producer]};
      cacc_reg_pkg::DATAOUT_SIZE_1_OFS: d = {19'd0, m_channel[m_producer]};
      cacc_reg_pkg::DATAOUT_ADDR_OFS:   d = m_addr[m_producer];
      cacc_reg_pkg::BATCHES_OFS:        d = {27'd0, m_batches[m_producer]};
      default:                          d = '0;  // unmapped
    endcase
    return d;
  endfunction

  task model_reset();
    m_producer  <= 1'b0;
    m_consumer  <= 1'b0;
    m_op_en     <= '0;
    m_conv_mode <= '0;
    m_width     <= '{default: '0};
    m_height    <= '{default: '0};
    m_channel   <= '{default: '0};
    m_addr      <= '{default: '0};
    m_batches   <= '{default: '0};
  endtask

  // called at the edge where the DUT takes the write
  task model_write(input cacc_reg_pkg::reg_offset_t ofs, input cacc_csb_pkg::csb_data_t d);
    if (ofs == cacc_reg_pkg::POINTER_OFS) begin
      m_producer <= d[0];
    end else if (ofs >= cacc_reg_pkg::DUAL_BASE_OFS && m_op_en[m_producer] == 1'b0) begin
      case (ofs)
        cacc_reg_pkg::OP_ENABLE_OFS: m_op_en[m_producer] <= d[0];
        cacc_reg_pkg::MISC_CFG_OFS:  m_conv_mode[m_producer] <= d[0];
        cacc_reg_pkg::DATAOUT_SIZE_0_OFS: begin
          m_width[m_producer]  <= d[12:0];
          m_height[m_producer] <= d[28:16];
        end
        cacc_reg_pkg::DATAOUT_SIZE_1_OFS: m_channel[m_producer] <= d[12:0];
        cacc_reg_pkg::DATAOUT_ADDR_OFS:   m_addr[m_producer] <= d;
        cacc_reg_pkg::BATCHES_OFS:        m_batches[m_producer] <= d[4:0];
        default: ;  // status and holes
      endcase
    end
  endtask

  ////////////////////
  // csb and datapath drivers
  ////////////////////
  task csb_access(input logic write, input logic nposted,
                  input cacc_reg_pkg::reg_offset_t ofs, input cacc_csb_pkg::csb_data_t wdat);
    @(posedge nvdla_core_clk);
    csb2cacc_req_pvld <= 1'b1;
    csb2cacc_req_pd   <= {7'd0, nposted, write, wdat, 12'd0, ofs[11:2]};  // word address
    exp_vld_n         <= ~write | nposted;
    exp_pd_n          <= write ? {1'b1, 1'b0, 32'd0} : {1'b0, 1'b0, model_read(ofs)};
    @(posedge nvdla_core_clk);
    csb2cacc_req_pvld <= 1'b0;
    exp_vld_n         <= 1'b0;
    @(posedge nvdla_core_clk);  // write lands here
    if (write) model_write(ofs, wdat);
  endtask

  task csb_write(input cacc_reg_pkg::reg_offset_t ofs, input cacc_csb_pkg::csb_data_t d,
                 input logic nposted);
    csb_access(1'b1, nposted, ofs, d);
  endtask

  task csb_read(input cacc_reg_pkg::reg_offset_t ofs);
    csb_access(1'b0, 1'b0, ofs, '0);
  endtask

  // one cycle done, consumer flips and its group stops at the next edge
  task pulse_done();
    @(posedge nvdla_core_clk);
    dp2reg_done <= 1'b1;
    @(posedge nvdla_core_clk);
    dp2reg_done             <= 1'b0;
    m_op_en[m_consumer]     <= 1'b0;
    m_consumer              <= ~m_consumer;
  endtask

//--- verification/cacc_regfile_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cacc_regfile_tb;

  localparam int TEST_CYCLES = 150;              // reset plus 35 csb accesses of 3 cycles, waits
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;  // margin

  logic                       nvdla_core_clk;
  logic                       nvdla_core_rstn;
  logic                       csb2cacc_req_pvld;
  cacc_csb_pkg::csb_req_pd_t  csb2cacc_req_pd;
  logic                       dp2reg_done;
  logic                       csb2cacc_req_prdy;
  logic                       cacc2csb_resp_valid;
  cacc_csb_pkg::csb_resp_pd_t cacc2csb_resp_pd;
  logic                       reg2dp_op_en;
  logic                       reg2dp_conv_mode;
  cacc_reg_pkg::dim_t         reg2dp_dataout_width;
  cacc_reg_pkg::dim_t         reg2dp_dataout_height;
  cacc_reg_pkg::dim_t         reg2dp_dataout_channel;
  cacc_csb_pkg::csb_data_t    reg2dp_dataout_addr;
  cacc_reg_pkg::batch_t       reg2dp_batches;

  logic                       exp_vld_n;    // beat on the bus wants a response
  cacc_csb_pkg::csb_resp_pd_t exp_pd_n;
  logic [1:0]                 exp_vld_q;    // response due two cycles later
  cacc_csb_pkg::csb_resp_pd_t exp_pd_q1;
  cacc_csb_pkg::csb_resp_pd_t exp_pd_q2;
  logic [2:0]                 exp_op_pipe;  // expected reg2dp_op_en lag
  logic [31:0]                lfsr = 32'h36e7_fd09;
  int                         err_cnt = 0;
  int                         err_mark = 0;
  int                         tests_run = 0;
  int                         tests_bad = 0;
  int                         cycle_cnt = 0;

  `include "cacc_tb_tasks.svh"

  cacc_regfile uut (.*);

  initial nvdla_core_clk = 1'b0;
  always #5 nvdla_core_clk = ~nvdla_core_clk;  // 10 ns

  always @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      exp_vld_q   <= '0;
      exp_op_pipe <= '0;
    end else begin
      exp_vld_q   <= {exp_vld_q[0], exp_vld_n};
      exp_pd_q1   <= exp_pd_n;
      exp_pd_q2   <= exp_pd_q1;
      exp_op_pipe <= dp2reg_done ? 3'b000 : {exp_op_pipe[1:0], m_op_en[m_consumer]};  // done flushes
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout, run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  // one lfsr step per bit taken
  function automatic cacc_csb_pkg::csb_data_t rand_word(input int nbits);
    cacc_csb_pkg::csb_data_t w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    err_cnt = err_cnt + 1;
  endtask

  ////////////////////
  // checks
  ////////////////////
  a_req_prdy: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb2cacc_req_prdy == 1'b1)
    else report_mismatch("csb2cacc_req_prdy", 64'($sampled(csb2cacc_req_prdy)), 64'h1);
  a_resp_valid: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    cacc2csb_resp_valid == exp_vld_q[1])
    else report_mismatch("cacc2csb_resp_valid", 64'($sampled(cacc2csb_resp_valid)),
                         64'($sampled(exp_vld_q[1])));
  a_resp_pd: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    exp_vld_q[1] |-> cacc2csb_resp_pd == exp_pd_q2)
    else report_mismatch("cacc2csb_resp_pd", 64'($sampled(cacc2csb_resp_pd)),
                         64'($sampled(exp_pd_q2)));
  a_op_en: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_op_en == exp_op_pipe[2])
    else report_mismatch("reg2dp_op_en", 64'($sampled(reg2dp_op_en)),
                         64'($sampled(exp_op_pipe[2])));
  a_conv_mode: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_conv_mode == m_conv_mode[m_consumer])
    else report_mismatch("reg2dp_conv_mode", 64'($sampled(reg2dp_conv_mode)),
                         64'($sampled(m_conv_mode[m_consumer])));
  a_size_0: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    {reg2dp_dataout_height, reg2dp_dataout_width} == {m_height[m_consumer], m_width[m_consumer]})
    else report_mismatch("reg2dp_dataout_height/width",
                         64'($sampled({reg2dp_dataout_height, reg2dp_dataout_width})),
                         64'($sampled({m_height[m_consumer], m_width[m_consumer]})));
  a_channel: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_dataout_channel == m_channel[m_consumer])
    else report_mismatch("reg2dp_dataout_channel", 64'($sampled(reg2dp_dataout_channel)),
                         64'($sampled(m_channel[m_consumer])));
  a_addr: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_dataout_addr == m_addr[m_consumer])
    else report_mismatch("reg2dp_dataout_addr", 64'($sampled(reg2dp_dataout_addr)),
                         64'($sampled(m_addr[m_consumer])));
  a_batches: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_batches == m_batches[m_consumer])
    else report_mismatch("reg2dp_batches", 64'($sampled(reg2dp_batches)),
                         64'($sampled(m_batches[m_consumer])));

  // random fields into whichever group the producer points at
  task fill_group();
    csb_write(cacc_reg_pkg::MISC_CFG_OFS, rand_word(1), 1'b0);
    csb_write(cacc_reg_pkg::DATAOUT_SIZE_0_OFS, rand_word(32), 1'b1);
    csb_write(cacc_reg_pkg::DATAOUT_SIZE_1_OFS, rand_word(16), 1'b0);
    csb_write(cacc_reg_pkg::DATAOUT_ADDR_OFS, rand_word(32), 1'b1);
    csb_write(cacc_reg_pkg::BATCHES_OFS, rand_word(8), 1'b0);
  endtask

  task read_group();
    for (int i = 0; i < 6; i++) begin
      csb_read(cacc_reg_pkg::reg_offset_t'(cacc_reg_pkg::OP_ENABLE_OFS + 4 * i));
    end
  endtask

  task finish_test(input string name);
    repeat (3) @(posedge nvdla_core_clk);  // last response reaches its check
    tests_run = tests_run + 1;
    if (err_cnt == err_mark) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial begin
    nvdla_core_rstn   <= 1'b0;
    csb2cacc_req_pvld <= 1'b0;
    csb2cacc_req_pd   <= '0;
    dp2reg_done       <= 1'b0;
    exp_vld_n         <= 1'b0;
    exp_pd_n          <= '0;
    model_reset();
    repeat (8) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;

    csb_read(cacc_reg_pkg::POINTER_OFS);
    csb_read(cacc_reg_pkg::STATUS_OFS);
    finish_test("reset values");

    fill_group();  // producer 0, group 0
    read_group();
    finish_test("group 0 fields");

    ////////////////////
    // ping-pong
    ////////////////////
    csb_write(cacc_reg_pkg::POINTER_OFS, 32'h1, 1'b1);
    fill_group();
    csb_write(cacc_reg_pkg::OP_ENABLE_OFS, 32'h1, 1'b0);  // group 1 queued
    csb_write(cacc_reg_pkg::POINTER_OFS, 32'h0, 1'b0);
    csb_write(cacc_reg_pkg::OP_ENABLE_OFS, 32'h1, 1'b1);  // group 0 runs
    csb_read(cacc_reg_pkg::STATUS_OFS);
    repeat (5) @(posedge nvdla_core_clk);  // op_en lag
    finish_test("enable both groups");

    pulse_done();
    csb_read(cacc_reg_pkg::POINTER_OFS);
    csb_read(cacc_reg_pkg::STATUS_OFS);
    repeat (5) @(posedge nvdla_core_clk);
    finish_test("done hands over");

    csb_write(cacc_reg_pkg::POINTER_OFS, 32'h1, 1'b1);
    csb_write(cacc_reg_pkg::MISC_CFG_OFS, rand_word(32), 1'b1);  // group 1 busy, dropped
    csb_write(cacc_reg_pkg::DATAOUT_ADDR_OFS, rand_word(32), 1'b0);
    csb_write(cacc_reg_pkg::OP_ENABLE_OFS, 32'h0, 1'b1);
    read_group();
    finish_test("running group locked");

    $display("tests run %0d, passed %0d, failed %0d, assertion errors %0d",
             tests_run, tests_run - tests_bad, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verification
logic/cacc_csb_pkg.sv
logic/cacc_reg_pkg.sv
logic/cacc_reg_access_if.sv
logic/cacc_cfg_if.sv
logic/cacc_csb_req_stage.sv
logic/cacc_single_group.sv
logic/cacc_dual_group.sv
logic/cacc_consumer_ctrl.sv
logic/cacc_csb_resp_stage.sv
logic/cacc_regfile.sv
verification/cacc_regfile_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f compile.f --top-module cacc_regfile_tb \
  -o cacc_regfile_sim > build.log 2>&1 \
  && ./obj_dir/cacc_regfile_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
